/* list.f */
logic/spi_pkg.sv
logic/byte_fifo.sv
logic/apb_regs.sv
logic/spi_shift_engine.sv
logic/spi_master_apb.sv
test/spi_slave_model.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module tb_top -Mdir obj_dir -f list.f \
  && ./obj_dir/Vtb_top 2>&1 | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }

/* test/tb_top.sv */
module tb_top
  import spi_pkg::*;
();

  logic               pclk;
  logic               rst;
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;
  logic               spi_sclk;
  logic               spi_mosi;
  logic               spi_miso;
  logic               spi_cs_n;
  logic               intr;

  logic               slave_cpol;
  logic               slave_cpha;
  logic               reply_valid;
  logic [FRAME_W-1:0] reply_byte;
  logic               got_valid;
  logic [FRAME_W-1:0] got_byte;

  logic [31:0]        seed;
  int                 cycles;
  int                 budget;

  // Reference model state
  logic [FRAME_W-1:0] tx_expect [$];
  logic [FRAME_W-1:0] reply_expect [$];
  logic [FRAME_W-1:0] got_log [$];

  spi_master_apb uut (
    .pclk     (pclk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .spi_cs_n (spi_cs_n),
    .intr     (intr)
  );

  spi_slave_model u_slave (
    .pclk        (pclk),
    .cpol        (slave_cpol),
    .cpha        (slave_cpha),
    .reply_valid (reply_valid),
    .reply_byte  (reply_byte),
    .sclk        (spi_sclk),
    .cs_n        (spi_cs_n),
    .mosi        (spi_mosi),
    .miso        (spi_miso),
    .got_valid   (got_valid),
    .got_byte    (got_byte)
  );

  always #2 pclk = ~pclk;

  always @(posedge pclk) begin
    if (got_valid) begin
      got_log.push_back(got_byte);
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  always @(posedge pclk) begin
    cycles = cycles + 1;
    if (cycles > budget) begin
      abort_run($sformatf("Timeout: the run went past its limit of %0d cycles", budget));
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Twice the frame time plus gap and 20 cycles per bus access
  task automatic extend_budget(input int frames, input int div, input int accesses);
    budget = budget + 2 * (frames * (18 * (div + 1) + 2) + 20 * accesses);
  endtask

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [FRAME_W-1:0] rand_byte();
    logic [31:0] r;
    r = lcg_next();
    return r[23:16];
  endfunction

  function automatic logic [DATA_W-1:0] ctrl_value(input logic en, input logic cpol,
                                                   input logic cpha, input logic intr_en,
                                                   input int div);
    return {16'd0, 8'(div), 4'd0, intr_en, cpha, cpol, en};
  endfunction

  task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                            output logic err);
    @(negedge pclk);
    apb_req.paddr   = addr;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge pclk);
    apb_req.penable = 1'b1;
    // Response taken at the edge that ends the access cycle
    @(posedge pclk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check("pready", 32'(apb_rsp.pready), 32'd1);
    @(negedge pclk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rdata;
    logic              err;
    apb_access(1'b1, addr, data, rdata, err);
    check($sformatf("pslverr on write to 0x%02h", addr), 32'(err), 32'd0);
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check($sformatf("pslverr on read of 0x%02h", addr), 32'(err), 32'd0);
  endtask

  task automatic set_slave_mode(input logic cpol, input logic cpha);
    @(posedge pclk);
    slave_cpol = cpol;
    slave_cpha = cpha;
  endtask

  task automatic queue_reply(input logic [FRAME_W-1:0] b);
    @(negedge pclk);
    reply_valid = 1'b1;
    reply_byte  = b;
    @(negedge pclk);
    reply_valid = 1'b0;
    reply_expect.push_back(b);
  endtask

  // Waits for room in the TX FIFO, then writes TXDATA
  task automatic send_byte(input logic [FRAME_W-1:0] b);
    logic [DATA_W-1:0] status;
    read_reg(REG_STATUS, status);
    while (status[STAT_TX_FULL]) begin
      read_reg(REG_STATUS, status);
    end
    write_reg(REG_TXDATA, {24'd0, b});
    tx_expect.push_back(b);
  endtask

  task automatic receive_bytes(input int n);
    logic [DATA_W-1:0]  status;
    logic [DATA_W-1:0]  data;
    logic [FRAME_W-1:0] exp_rx;
    logic [FRAME_W-1:0] exp_tx;
    logic [FRAME_W-1:0] seen_tx;
    for (int i = 0; i < n; i++) begin
      read_reg(REG_STATUS, status);
      while (status[STAT_RX_EMPTY]) begin
        read_reg(REG_STATUS, status);
      end
      read_reg(REG_RXDATA, data);
      exp_rx = reply_expect.pop_front();
      check("RXDATA", data, {24'd0, exp_rx});
      if (got_log.size() == 0) begin
        abort_run("The SPI slave logged no byte for a frame that completed");
      end
      seen_tx = got_log.pop_front();
      exp_tx  = tx_expect.pop_front();
      check("spi_mosi byte", {24'd0, seen_tx}, {24'd0, exp_tx});
    end
  endtask

  // Returns once busy has stayed low for frame_cycles
  task automatic wait_quiet(input int frame_cycles);
    logic [DATA_W-1:0] status;
    int                quiet;
    quiet = 0;
    while (quiet < frame_cycles) begin
      read_reg(REG_STATUS, status);
      if (status[STAT_BUSY]) begin
        quiet = 0;
      end else begin
        quiet = quiet + 3;
      end
    end
  endtask

  initial begin
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] val;
    logic              err;
    logic [31:0]       r;
    logic              cpol;
    logic              cpha;
    int                div;

    pclk        = 1'b0;
    rst         = 1'b1;
    apb_req     = '0;
    slave_cpol  = 1'b0;
    slave_cpha  = 1'b0;
    reply_valid = 1'b0;
    reply_byte  = '0;
    seed        = 32'h1b47c58f;
    cycles      = 0;
    budget      = 20;
    repeat (5) @(negedge pclk);
    rst = 1'b0;

    // Pins idle after reset
    check("spi_cs_n after reset", 32'(spi_cs_n), 32'd1);
    check("spi_sclk after reset", 32'(spi_sclk), 32'd0);
    check("intr after reset", 32'(intr), 32'd0);

    // CTRL read-back and STATUS after reset
    extend_budget(0, 0, 12);
    read_reg(REG_STATUS, data);
    check("STATUS after reset", data, (32'd1 << STAT_TX_EMPTY) | (32'd1 << STAT_RX_EMPTY));
    repeat (4) begin
      val = lcg_next();
      write_reg(REG_CTRL, val);
      read_reg(REG_CTRL, data);
      check("CTRL", data, val & 32'h0000ff0f);
    end
    write_reg(REG_CTRL, '0);

    // All four SPI modes
    for (int m = 0; m < 4; m++) begin
      cpol = m[1];
      cpha = m[0];
      r    = lcg_next();
      div  = int'(r[9:8]);
      extend_budget(4, div, 40);
      set_slave_mode(cpol, cpha);
      repeat (4) queue_reply(rand_byte());
      write_reg(REG_CTRL, ctrl_value(1'b1, cpol, cpha, 1'b0, div));
      repeat (4) send_byte(rand_byte());
      receive_bytes(4);
    end

    // FIFO limits and error responses with the engine held off
    extend_budget(0, 0, 30);
    write_reg(REG_CTRL, '0);
    repeat (16) begin
      val = {24'd0, rand_byte()};
      write_reg(REG_TXDATA, val);
      tx_expect.push_back(val[FRAME_W-1:0]);
    end
    read_reg(REG_STATUS, data);
    check("STATUS tx_full", 32'(data[STAT_TX_FULL]), 32'd1);
    apb_access(1'b1, REG_TXDATA, 32'h5a, data, err);
    check("pslverr on write to full TXDATA", 32'(err), 32'd1);
    apb_access(1'b0, 8'h10, '0, data, err);
    check("pslverr on unmapped offset", 32'(err), 32'd1);
    apb_access(1'b1, REG_RXDATA, 32'h33, data, err);
    check("pslverr on write to RXDATA", 32'(err), 32'd1);
    apb_access(1'b0, REG_RXDATA, '0, data, err);
    check("pslverr on empty RXDATA read", 32'(err), 32'd1);

    // Interrupt with intr_en set while the 16 queued bytes drain
    div = 1;
    extend_budget(17, div, 90);
    set_slave_mode(1'b0, 1'b0);
    repeat (16) queue_reply(rand_byte());
    write_reg(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0, 1'b1, div));
    while (intr !== 1'b1) begin
      @(negedge pclk);
    end
    receive_bytes(16);
    wait_quiet(18 * (div + 1) + 2);
    check("intr before clear", 32'(intr), 32'd1);
    write_reg(REG_STATUS, 32'd1);
    check("intr after clear", 32'(intr), 32'd0);

    // Same with intr_en clear
    write_reg(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0, 1'b0, div));
    queue_reply(rand_byte());
    send_byte(rand_byte());
    receive_bytes(1);
    read_reg(REG_STATUS, data);
    check("STATUS done", 32'(data[STAT_DONE]), 32'd1);
    check("intr with intr_en clear", 32'(intr), 32'd0);

    // RX back-pressure with 20 bytes sent before any read
    r    = lcg_next();
    cpol = r[4];
    cpha = r[5];
    div  = int'(r[9:8]);
    extend_budget(21, div, 140);
    set_slave_mode(cpol, cpha);
    repeat (20) queue_reply(rand_byte());
    write_reg(REG_CTRL, ctrl_value(1'b1, cpol, cpha, 1'b0, div));
    repeat (20) send_byte(rand_byte());
    wait_quiet(18 * (div + 1) + 2);
    check("spi_sclk idle", 32'(spi_sclk), 32'(cpol));
    check("spi_cs_n idle", 32'(spi_cs_n), 32'd1);
    read_reg(REG_STATUS, data);
    check("STATUS rx_full", 32'(data[STAT_RX_FULL]), 32'd1);
    check("STATUS tx_empty", 32'(data[STAT_TX_EMPTY]), 32'd0);
    receive_bytes(20);

    check("bytes left in slave log", 32'(got_log.size()), 32'd0);
    read_reg(REG_STATUS, data);
    check("STATUS at end", data,
          (32'd1 << STAT_DONE) | (32'd1 << STAT_TX_EMPTY) | (32'd1 << STAT_RX_EMPTY));
    $display("Everything OK");
    $finish;
  end

endmodule

/* test/spi_slave_model.sv */
module spi_slave_model
  import spi_pkg::*;
(
  input  logic               pclk,
  input  logic               cpol,
  input  logic               cpha,
  input  logic               reply_valid,
  input  logic [FRAME_W-1:0] reply_byte,
  input  logic               sclk,
  input  logic               cs_n,
  input  logic               mosi,
  output logic               miso,
  output logic               got_valid,
  output logic [FRAME_W-1:0] got_byte
);

  logic [FRAME_W-1:0] replies [$];
  logic [FRAME_W-1:0] tx_byte;
  logic [FRAME_W-1:0] rx_byte;
  int                 bit_cnt;
  logic               prev_sclk;
  logic               prev_cs_n;
  logic               leading;

  initial begin
    tx_byte   = '0;
    rx_byte   = '0;
    bit_cnt   = 0;
    prev_sclk = 1'b0;
    prev_cs_n = 1'b1;
    leading   = 1'b0;
    got_valid = 1'b0;
    got_byte  = '0;
  end

  // MSB of the current reply is always on the line
  assign miso = tx_byte[FRAME_W-1];

  always @(posedge pclk) begin
    if (reply_valid) begin
      replies.push_back(reply_byte);
    end
  end

  // Bus pins only move on rising pclk, so look at them half a cycle later
  always @(negedge pclk) begin
    got_valid = 1'b0;
    if (prev_cs_n && !cs_n) begin
      // Frame start; in mode 1 and 3 this also swallows the first leading edge
      if (replies.size() > 0) begin
        tx_byte = replies.pop_front();
      end else begin
        tx_byte = '0;
      end
      bit_cnt = 0;
    end else if (!cs_n && (sclk != prev_sclk)) begin
      leading = (sclk != cpol);
      if (leading != cpha) begin
        // Sample edge
        rx_byte = {rx_byte[FRAME_W-2:0], mosi};
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == FRAME_W) begin
          got_valid = 1'b1;
          got_byte  = rx_byte;
        end
      end else if (bit_cnt > 0) begin
        tx_byte = {tx_byte[FRAME_W-2:0], 1'b0};
      end
    end
    prev_sclk = sclk;
    prev_cs_n = cs_n;
  end

endmodule

/* logic/spi_master_apb.sv */
module spi_master_apb
  import spi_pkg::*;
(
  input  logic     pclk,
  input  logic     rst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output logic     spi_sclk,
  output logic     spi_mosi,
  input  logic     spi_miso,
  output logic     spi_cs_n,
  output logic     intr
);

  spi_cfg_t           cfg;
  logic               busy;
  logic               frame_done;

  // TX path, APB to engine
  logic               tx_push;
  logic               tx_pop;
  logic               tx_full;
  logic               tx_empty;
  logic [FRAME_W-1:0] tx_wdata;
  logic [FRAME_W-1:0] tx_rdata;

  // RX path, engine to APB
  logic               rx_push;
  logic               rx_pop;
  logic               rx_full;
  logic               rx_empty;
  logic [FRAME_W-1:0] rx_wdata;
  logic [FRAME_W-1:0] rx_rdata;

  apb_regs u_regs (
    .pclk       (pclk),
    .rst        (rst),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .cfg        (cfg),
    .intr       (intr),
    .tx_push    (tx_push),
    .tx_data    (tx_wdata),
    .tx_full    (tx_full),
    .tx_empty   (tx_empty),
    .rx_pop     (rx_pop),
    .rx_data    (rx_rdata),
    .rx_full    (rx_full),
    .rx_empty   (rx_empty),
    .busy       (busy),
    .frame_done (frame_done)
  );

  byte_fifo u_tx_fifo (
    .pclk  (pclk),
    .rst   (rst),
    .push  (tx_push),
    .wdata (tx_wdata),
    .pop   (tx_pop),
    .rdata (tx_rdata),
    .full  (tx_full),
    .empty (tx_empty)
  );

  byte_fifo u_rx_fifo (
    .pclk  (pclk),
    .rst   (rst),
    .push  (rx_push),
    .wdata (rx_wdata),
    .pop   (rx_pop),
    .rdata (rx_rdata),
    .full  (rx_full),
    .empty (rx_empty)
  );

  spi_shift_engine u_engine (
    .pclk       (pclk),
    .rst        (rst),
    .cfg        (cfg),
    .tx_data    (tx_rdata),
    .tx_empty   (tx_empty),
    .rx_full    (rx_full),
    .tx_pop     (tx_pop),
    .rx_push    (rx_push),
    .rx_data    (rx_wdata),
    .frame_done (frame_done),
    .busy       (busy),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_cs_n   (spi_cs_n),
    .spi_miso   (spi_miso)
  );

endmodule

/* logic/spi_shift_engine.sv */
module spi_shift_engine
  import spi_pkg::*;
(
  input  logic               pclk,
  input  logic               rst,
  input  spi_cfg_t           cfg,
  input  logic [FRAME_W-1:0] tx_data,
  input  logic               tx_empty,
  input  logic               rx_full,
  output logic               tx_pop,
  output logic               rx_push,
  output logic [FRAME_W-1:0] rx_data,
  output logic               frame_done,
  output logic               busy,
  output logic               spi_sclk,
  output logic               spi_mosi,
  output logic               spi_cs_n,
  input  logic               spi_miso
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_GAP
  } state_t;

  state_t             state;
  logic [DIV_W-1:0]   div_cnt;
  logic [HALF_W-1:0]  half_cnt;
  logic [FRAME_W-1:0] tx_shift;
  logic [FRAME_W-1:0] rx_shift;
  logic               sclk_q;
  logic               cs_n_q;
  logic               rx_push_q;
  logic               done_q;
  logic               start;
  logic               half_end;
  logic               last_half;

  // Full RX FIFO holds off the next frame
  assign start = (state == ST_IDLE) && cfg.enable && !tx_empty && !rx_full;

  // >= so a divider change mid frame cannot stretch a half period
  assign half_end  = (div_cnt >= cfg.clk_div);
  assign last_half = (half_cnt == (HALF_W)'(FRAME_HALVES - 1));

  always_ff @(posedge pclk) begin
    if (rst) begin
      state     <= ST_IDLE;
      div_cnt   <= '0;
      half_cnt  <= '0;
      tx_shift  <= '0;
      sclk_q    <= 1'b0;
      cs_n_q    <= 1'b1;
      rx_push_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      rx_push_q <= 1'b0;
      done_q    <= 1'b0;
      case (state)
        ST_IDLE: begin
          div_cnt  <= '0;
          half_cnt <= '0;
          sclk_q   <= cfg.cpol;
          if (start) begin
            state    <= ST_SHIFT;
            tx_shift <= tx_data;
            cs_n_q   <= 1'b0;
            // Mode 1 and 3 make their leading edge right here
            sclk_q   <= cfg.cpol ^ cfg.cpha;
          end
        end
        ST_SHIFT: begin
          if (half_end) begin
            div_cnt  <= '0;
            half_cnt <= half_cnt + 1'b1;
            // Even halves end in a sample, odd halves in a shift
            if (half_cnt[0]) begin
              tx_shift <= {tx_shift[FRAME_W-2:0], 1'b0};
            end
            if (last_half) begin
              state     <= ST_GAP;
              sclk_q    <= cfg.cpol;
              cs_n_q    <= 1'b1;
              rx_push_q <= 1'b1;
              done_q    <= 1'b1;
            end else begin
              sclk_q <= ~sclk_q;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        ST_GAP: begin
          // CS stays high for one half period
          if (half_end) begin
            div_cnt <= '0;
            state   <= ST_IDLE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // MISO capture, MSB first
  always_ff @(posedge pclk) begin
    if (state == ST_SHIFT && half_end && !half_cnt[0]) begin
      rx_shift <= {rx_shift[FRAME_W-2:0], spi_miso};
    end
  end

  assign tx_pop     = start;
  assign rx_push    = rx_push_q;
  assign rx_data    = rx_shift;
  assign frame_done = done_q;
  assign busy       = (state != ST_IDLE);
  assign spi_sclk   = sclk_q;
  assign spi_mosi   = tx_shift[FRAME_W-1];
  assign spi_cs_n   = cs_n_q;

endmodule

/* logic/apb_regs.sv */
module apb_regs
  import spi_pkg::*;
(
  input  logic               pclk,
  input  logic               rst,
  input  apb_req_t           apb_req,
  output apb_rsp_t           apb_rsp,
  output spi_cfg_t           cfg,
  output logic               intr,
  output logic               tx_push,
  output logic [FRAME_W-1:0] tx_data,
  input  logic               tx_full,
  input  logic               tx_empty,
  output logic               rx_pop,
  input  logic [FRAME_W-1:0] rx_data,
  input  logic               rx_full,
  input  logic               rx_empty,
  input  logic               busy,
  input  logic               frame_done
);

  spi_cfg_t          cfg_q;
  logic              intr_en_q;
  logic              done_q;

  logic              access;
  logic              wr_en;
  logic              rd_en;
  logic              sel_ctrl;
  logic              sel_status;
  logic              sel_tx;
  logic              sel_rx;
  logic              bad_access;
  logic              good_wr;
  logic              good_rd;
  logic [DATA_W-1:0] ctrl_word;
  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] rdata;

  // Access phase only, no wait states
  assign access = apb_req.psel && apb_req.penable;
  assign wr_en  = access && apb_req.pwrite;
  assign rd_en  = access && !apb_req.pwrite;

  assign sel_ctrl   = (apb_req.paddr == REG_CTRL);
  assign sel_status = (apb_req.paddr == REG_STATUS);
  assign sel_tx     = (apb_req.paddr == REG_TXDATA);
  assign sel_rx     = (apb_req.paddr == REG_RXDATA);

  // Error decode, valid only while access is high
  always_comb begin
    if (sel_ctrl) begin
      bad_access = 1'b0;
    end else if (sel_status) begin
      bad_access = apb_req.pwrite && !apb_req.pwdata[STAT_DONE];
    end else if (sel_tx) begin
      bad_access = apb_req.pwrite && tx_full;
    end else if (sel_rx) begin
      // RXDATA is read only and must hold data
      bad_access = apb_req.pwrite || rx_empty;
    end else begin
      bad_access = 1'b1;
    end
  end

  assign good_wr = wr_en && !bad_access;
  assign good_rd = rd_en && !bad_access;

  // FIFO side
  assign tx_push = good_wr && sel_tx;
  assign tx_data = apb_req.pwdata[FRAME_W-1:0];
  assign rx_pop  = good_rd && sel_rx;

  always_ff @(posedge pclk) begin
    if (rst) begin
      cfg_q     <= '0;
      intr_en_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (good_wr && sel_ctrl) begin
        cfg_q.enable  <= apb_req.pwdata[CTRL_ENABLE];
        cfg_q.cpol    <= apb_req.pwdata[CTRL_CPOL];
        cfg_q.cpha    <= apb_req.pwdata[CTRL_CPHA];
        cfg_q.clk_div <= apb_req.pwdata[CTRL_DIV_LSB +: DIV_W];
        intr_en_q     <= apb_req.pwdata[CTRL_INTR_EN];
      end
      // A new frame end beats a clear in the same cycle
      if (frame_done) begin
        done_q <= 1'b1;
      end else if (good_wr && sel_status) begin
        done_q <= 1'b0;
      end
    end
  end

  always_comb begin
    ctrl_word                              = '0;
    ctrl_word[CTRL_ENABLE]                 = cfg_q.enable;
    ctrl_word[CTRL_CPOL]                   = cfg_q.cpol;
    ctrl_word[CTRL_CPHA]                   = cfg_q.cpha;
    ctrl_word[CTRL_INTR_EN]                = intr_en_q;
    ctrl_word[CTRL_DIV_LSB +: DIV_W]       = cfg_q.clk_div;
  end

  always_comb begin
    status_word                = '0;
    status_word[STAT_DONE]     = done_q;
    status_word[STAT_BUSY]     = busy;
    status_word[STAT_TX_FULL]  = tx_full;
    status_word[STAT_TX_EMPTY] = tx_empty;
    status_word[STAT_RX_FULL]  = rx_full;
    status_word[STAT_RX_EMPTY] = rx_empty;
  end

  // Read mux
  always_comb begin
    rdata = '0;
    if (rd_en) begin
      if (sel_ctrl) begin
        rdata = ctrl_word;
      end else if (sel_status) begin
        rdata = status_word;
      end else if (sel_rx) begin
        rdata[FRAME_W-1:0] = rx_data;
      end
    end
  end

  assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access && bad_access};

  assign cfg  = cfg_q;
  assign intr = done_q && intr_en_q;

endmodule

/* logic/byte_fifo.sv */
module byte_fifo
  import spi_pkg::*;
(
  input  logic               pclk,
  input  logic               rst,
  input  logic               push,
  input  logic [FRAME_W-1:0] wdata,
  input  logic               pop,
  output logic [FRAME_W-1:0] rdata,
  output logic               full,
  output logic               empty
);

  logic [FRAME_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;
  logic               do_push;
  logic               do_pop;

  // Push when full and pop when empty are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Head entry is always on the read port
  assign rdata = mem[rd_ptr];

  always_ff @(posedge pclk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* logic/spi_pkg.sv */
package spi_pkg;

  // Bus and frame widths
  localparam int ADDR_W     = 8;
  localparam int DATA_W     = 32;
  localparam int FRAME_W    = 8;
  localparam int DIV_W      = 8;

  // FIFO sizing, PTR_W is log2 of the depth
  localparam int FIFO_DEPTH = 16;
  localparam int PTR_W      = 4;

  // One frame is two SCLK half periods per bit
  localparam int FRAME_HALVES = 2 * FRAME_W;
  localparam int HALF_W       = 4;

  // Register offsets
  localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h00;
  localparam logic [ADDR_W-1:0] REG_STATUS = 8'h04;
  localparam logic [ADDR_W-1:0] REG_TXDATA = 8'h08;
  localparam logic [ADDR_W-1:0] REG_RXDATA = 8'h0C;

  // CTRL bit positions
  localparam int CTRL_ENABLE  = 0;
  localparam int CTRL_CPOL    = 1;
  localparam int CTRL_CPHA    = 2;
  localparam int CTRL_INTR_EN = 3;
  localparam int CTRL_DIV_LSB = 8;

  // STATUS bit positions
  localparam int STAT_DONE     = 0;
  localparam int STAT_BUSY     = 1;
  localparam int STAT_TX_FULL  = 2;
  localparam int STAT_TX_EMPTY = 3;
  localparam int STAT_RX_FULL  = 4;
  localparam int STAT_RX_EMPTY = 5;

  // Driven by the bus master
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  // Driven by the slave
  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // What the shift engine needs from CTRL
  typedef struct packed {
    logic             enable;
    logic             cpol;
    logic             cpha;
    logic [DIV_W-1:0] clk_div;
  } spi_cfg_t;

endpackage
